/* verilog/cps_bus_pkg.sv */
// CPS main bus definitions
`default_nettype none

package cps_bus_pkg;

    // word address, byte address bits 23:1
    typedef union packed {
        struct packed {
            logic [5:0]  region;
            logic [1:0]  bank;
            logic [14:0] offset;
        } region_view;
        // upper covers byte address 23:9
        struct packed {
            logic [14:0] upper;
            logic [5:0]  io_sel;
            logic [1:0]  io_idx;
        } io_view;
    } cpu_addr_t;

    typedef enum logic [2:0] {
        reg_none,
        reg_rom,
        reg_ram,
        reg_vram,
        reg_io,
        reg_iack
    } region_t;

    // cycles from start to done
    localparam logic [2:0] SLOW_WAIT = 3'd3;
    localparam logic [2:0] FAST_WAIT = 3'd2;

    // io_sel codes, byte address 8:3
    localparam logic [5:0] IO_JOY    = 6'd0;
    localparam logic [5:0] IO_SYS    = 6'd3;
    localparam logic [5:0] IO_OLATCH = 6'd6;
    localparam logic [5:0] IO_SND0   = 6'd48;
    localparam logic [5:0] IO_SND1   = 6'd49;

    localparam logic [15:0] OPEN_BUS = 16'hffff;

endpackage

`default_nettype wire

/* verilog/cps_bus_ifs.sv */
// CPS main bus interfaces
`timescale 1ns/1ps
`default_nettype none

// one access from the request port to the sequencer
interface cpu_bus_if;
    import cps_bus_pkg::*;

    logic        start;
    logic        we;
    logic [1:0]  be;
    logic        iack;
    cpu_addr_t   addr;
    logic [15:0] wdata;
    logic [15:0] rdata;
    logic        done;

    modport port (
        output start, we, be, iack, addr, wdata,
        input  rdata, done
    );

    modport seq (
        input  start, we, be, iack, addr, wdata,
        output rdata, done
    );
endinterface

// memory region request, sel held until done
interface mem_req_if;
    import cps_bus_pkg::*;

    region_t     sel;
    cpu_addr_t   addr;
    logic        we;
    logic [1:0]  be;
    logic [15:0] wdata;
    logic [15:0] rdata;
    logic        done;

    modport seq (
        output sel, addr, we, be, wdata,
        input  rdata, done
    );

    modport mem (
        input  sel, addr, we, be, wdata,
        output rdata, done
    );
endinterface

// cabinet register access, rdata one cycle after strobe
interface io_req_if;
    import cps_bus_pkg::*;

    logic        strobe;
    logic        we;
    logic [1:0]  be;
    logic        iack;
    cpu_addr_t   addr;
    logic [15:0] wdata;
    logic [15:0] rdata;

    modport seq (
        output strobe, we, be, iack, addr, wdata,
        input  rdata
    );

    modport io (
        input  strobe, we, be, iack, addr, wdata,
        output rdata
    );
endinterface

`default_nettype wire

/* verilog/bus_request_port.sv */
// Bus request port
`timescale 1ns/1ps
`default_nettype none

module bus_request_port (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   req,
    input  logic                   we,
    input  logic [1:0]             be,
    input  logic                   iack,
    input  cps_bus_pkg::cpu_addr_t addr,
    input  logic [15:0]            wdata,
    output logic                   ack,
    output logic [15:0]            rdata,
    cpu_bus_if.port                bus
);

    // idle when neither busy nor ack is set
    logic busy;
    logic idle;

    assign idle = !busy && !ack;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy      <= 1'b0;
            ack       <= 1'b0;
            bus.start <= 1'b0;
        end else begin
            bus.start <= 1'b0;
            if (idle) begin
                if (req) begin
                    busy      <= 1'b1;
                    bus.start <= 1'b1;
                end
            end else if (busy) begin
                if (bus.done) begin
                    busy <= 1'b0;
                    ack  <= 1'b1;
                end
            end else if (!req) begin
                // master released the request
                ack <= 1'b0;
            end
        end
    end

    // request fields frozen for the whole access
    always_ff @(posedge clk) begin
        if (idle && req) begin
            bus.we    <= we;
            bus.be    <= be;
            bus.iack  <= iack;
            bus.addr  <= addr;
            bus.wdata <= wdata;
        end
        if (busy && bus.done) begin
            rdata <= bus.rdata;
        end
    end

    ack_needs_req: assert property (@(posedge clk) disable iff (rst)
        $rose(ack) |-> req);

endmodule

`default_nettype wire

/* verilog/access_sequencer.sv */
// Access sequencer
`timescale 1ns/1ps
`default_nettype none

module access_sequencer (
    input  logic    clk,
    input  logic    rst,
    cpu_bus_if.seq  cpu,
    mem_req_if.seq  mem,
    io_req_if.seq   io
);
    import cps_bus_pkg::*;

    logic [5:0] hi;
    region_t    region;
    region_t    region_q;
    logic       slow;
    logic       slow_q;
    logic       active;
    logic [2:0] cnt;
    logic [2:0] min_wait;
    logic       mem_seen;
    logic       to_mem;
    logic       finish;

    assign hi   = cpu.addr.region_view.region;
    // slow when A23 set or A22 clear
    assign slow = hi[5] | ~hi[4];

    always_comb begin
        if (cpu.iack) begin
            region = reg_iack;
        end else if (hi[5:4] == 2'b00) begin
            region = reg_rom;
        end else if (&hi) begin
            region = reg_ram;
        end else if (hi == 6'b100100 && cpu.addr.region_view.bank != 2'b11) begin
            region = reg_vram;
        end else if (hi[5:2] == 4'b1000) begin
            region = reg_io;
        end else begin
            region = reg_none;
        end
    end

    assign to_mem   = region_q == reg_rom || region_q == reg_ram || region_q == reg_vram;
    assign min_wait = slow_q ? SLOW_WAIT : 3'd1;

    // cnt holds cycles elapsed since start
    always_comb begin
        if (to_mem) begin
            finish = (mem.done || mem_seen) && cnt >= min_wait - 3'd1;
        end else begin
            finish = cnt == FAST_WAIT - 3'd1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            active    <= 1'b0;
            cnt       <= 3'd0;
            slow_q    <= 1'b0;
            mem_seen  <= 1'b0;
            region_q  <= reg_none;
            mem.sel   <= reg_none;
            io.strobe <= 1'b0;
            cpu.done  <= 1'b0;
        end else begin
            cpu.done  <= 1'b0;
            io.strobe <= 1'b0;
            if (cpu.start) begin
                active    <= 1'b1;
                cnt       <= 3'd1;
                slow_q    <= slow;
                mem_seen  <= 1'b0;
                region_q  <= region;
                io.strobe <= region == reg_io || region == reg_iack;
                if (region == reg_rom || region == reg_ram || region == reg_vram) begin
                    mem.sel <= region;
                end
            end else if (active) begin
                if (cnt != 3'd7) begin
                    cnt <= cnt + 3'd1;
                end
                if (mem.done) begin
                    mem_seen <= 1'b1;
                    mem.sel  <= reg_none;
                end
                if (finish) begin
                    active   <= 1'b0;
                    cpu.done <= 1'b1;
                end
            end
        end
    end

    // fields are stable for the whole access
    assign mem.addr  = cpu.addr;
    assign mem.we    = cpu.we;
    assign mem.be    = cpu.be;
    assign mem.wdata = cpu.wdata;
    assign io.addr   = cpu.addr;
    assign io.we     = cpu.we;
    assign io.be     = cpu.be;
    assign io.iack   = cpu.iack;
    assign io.wdata  = cpu.wdata;

    always_comb begin
        case (region_q)
            reg_rom, reg_ram, reg_vram: cpu.rdata = mem.rdata;
            reg_io:                     cpu.rdata = io.rdata;
            default:                    cpu.rdata = OPEN_BUS;
        endcase
    end

    mem_done_in_access: assert property (@(posedge clk) disable iff (rst)
        mem.done |-> active);

    start_when_idle: assert property (@(posedge clk) disable iff (rst)
        cpu.start |-> !active);

endmodule

`default_nettype wire

/* verilog/io_control.sv */
// Cabinet I/O and interrupt control
`timescale 1ns/1ps
`default_nettype none

module io_control (
    input  logic       clk,
    input  logic       rst,
    io_req_if.io       io,
    input  logic       lvbl,
    input  logic [7:0] joystick1,
    input  logic [7:0] joystick2,
    input  logic [1:0] start_button,
    input  logic [1:0] coin_input,
    input  logic       service,
    input  logic       tilt,
    input  logic       dip_test,
    input  logic [7:0] dipsw_a,
    input  logic [7:0] dipsw_b,
    input  logic [7:0] dipsw_c,
    output logic [7:0] snd0_latch,
    output logic [7:0] snd1_latch,
    output logic       ppu_rstn,
    output logic       ppu_cs,
    output logic       irq_vblank
);
    import cps_bus_pkg::*;

    logic [5:0]  sel;
    logic [1:0]  idx;
    logic        wr;
    logic        olatch_wr;
    logic        snd0_wr;
    logic        snd1_wr;
    logic        ppu_wr;
    logic        iack_clr;
    logic        lvbl_q;
    logic [15:0] rd;

    assign sel = io.addr.io_view.io_sel;
    assign idx = io.addr.io_view.io_idx;

    assign wr        = io.strobe && io.we && !io.iack;
    assign olatch_wr = wr && sel == IO_OLATCH && io.be[1];
    assign snd0_wr   = wr && sel == IO_SND0 && io.be[0];
    assign snd1_wr   = wr && sel == IO_SND1 && io.be[0];
    assign ppu_wr    = wr && sel[5:3] == 3'b100;
    assign iack_clr  = io.strobe && io.iack;

    always_comb begin
        case (sel)
            IO_JOY: rd = {joystick2, joystick1};
            IO_SYS: begin
                case (idx)
                    2'd0:    rd = {tilt, dip_test, start_button, 1'b1, service,
                                   coin_input, 8'hff};
                    2'd1:    rd = {dipsw_a, 8'hff};
                    2'd2:    rd = {dipsw_b, 8'hff};
                    default: rd = {dipsw_c, 8'hff};
                endcase
            end
            default: rd = OPEN_BUS;
        endcase
    end

    always_ff @(posedge clk) begin
        if (io.strobe && !io.we && !io.iack) begin
            io.rdata <= rd;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            snd0_latch <= 8'd0;
            snd1_latch <= 8'd0;
            ppu_rstn   <= 1'b0;
            ppu_cs     <= 1'b0;
            irq_vblank <= 1'b0;
            lvbl_q     <= 1'b0;
        end else begin
            lvbl_q <= lvbl;
            ppu_cs <= ppu_wr;
            if (olatch_wr) begin
                ppu_rstn <= ~io.wdata[15];
            end
            if (snd0_wr) begin
                snd0_latch <= io.wdata[7:0];
            end
            if (snd1_wr) begin
                snd1_latch <= io.wdata[7:0];
            end
            // acknowledge beats a coincident vblank edge
            if (iack_clr) begin
                irq_vblank <= 1'b0;
            end else if (lvbl_q && !lvbl) begin
                irq_vblank <= 1'b1;
            end
        end
    end

    // one strobe per access keeps ppu_cs to a single pulse
    strobe_one_cycle: assert property (@(posedge clk) disable iff (rst)
        io.strobe |=> !io.strobe);

endmodule

`default_nettype wire

/* verilog/memory_port.sv */
// Memory port
`timescale 1ns/1ps
`default_nettype none

module memory_port (
    input  logic        clk,
    input  logic        rst,
    mem_req_if.mem      mem,
    input  logic [15:0] rom_data,
    input  logic        rom_ok,
    input  logic [15:0] ram_data,
    input  logic        ram_ok,
    output logic        rom_cs,
    output logic [19:1] rom_addr,
    output logic        ram_cs,
    output logic        vram_cs,
    output logic [17:1] ram_addr,
    output logic        ram_we,
    output logic [1:0]  ram_be,
    output logic [15:0] ram_wdata
);
    import cps_bus_pkg::*;

    logic busy;
    logic rom_hit;
    logic ram_hit;

    assign busy    = rom_cs | ram_cs | vram_cs;
    assign rom_hit = rom_cs && rom_ok;
    assign ram_hit = (ram_cs || vram_cs) && ram_ok;

    assign rom_addr  = mem.addr[18:0];
    assign ram_addr  = mem.addr[16:0];
    assign ram_we    = mem.we && (ram_cs || vram_cs);
    assign ram_be    = mem.be;
    assign ram_wdata = mem.wdata;

    // selects are registered so they stay clean while sel settles
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rom_cs   <= 1'b0;
            ram_cs   <= 1'b0;
            vram_cs  <= 1'b0;
            mem.done <= 1'b0;
        end else begin
            mem.done <= 1'b0;
            if (busy) begin
                if (rom_hit || ram_hit) begin
                    rom_cs   <= 1'b0;
                    ram_cs   <= 1'b0;
                    vram_cs  <= 1'b0;
                    mem.done <= 1'b1;
                end
            end else if (mem.sel != reg_none && !mem.done) begin
                case (mem.sel)
                    reg_rom: begin
                        // ROM writes complete without touching the chip
                        if (mem.we) begin
                            mem.done <= 1'b1;
                        end else begin
                            rom_cs <= 1'b1;
                        end
                    end
                    reg_ram:  ram_cs  <= 1'b1;
                    reg_vram: vram_cs <= 1'b1;
                    default:  mem.done <= 1'b1;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rom_hit) begin
            mem.rdata <= rom_data;
        end else if (ram_hit) begin
            mem.rdata <= ram_data;
        end
    end

    // one select at a time and it matches the region being served
    cs_matches_sel: assert property (@(posedge clk) disable iff (rst)
        busy |-> {rom_cs, ram_cs, vram_cs} ==
                 {mem.sel == reg_rom, mem.sel == reg_ram, mem.sel == reg_vram});

    sel_held_to_done: assert property (@(posedge clk) disable iff (rst)
        mem.sel != reg_none && !mem.done |=> $stable(mem.sel));

endmodule

`default_nettype wire

/* verilog/cps_main_bus.sv */
// CPS main bus top level
`timescale 1ns/1ps
`default_nettype none

module cps_main_bus (
    input  logic        clk,
    input  logic        rst,
    // external master
    input  logic        req,
    input  logic        we,
    input  logic [1:0]  be,
    input  logic        iack,
    input  logic [23:1] addr,
    input  logic [15:0] wdata,
    output logic        ack,
    output logic [15:0] rdata,
    // ROM
    output logic        rom_cs,
    output logic [19:1] rom_addr,
    input  logic [15:0] rom_data,
    input  logic        rom_ok,
    // work RAM and VRAM
    output logic        ram_cs,
    output logic        vram_cs,
    output logic [17:1] ram_addr,
    output logic        ram_we,
    output logic [1:0]  ram_be,
    output logic [15:0] ram_wdata,
    input  logic [15:0] ram_data,
    input  logic        ram_ok,
    // cabinet
    input  logic        lvbl,
    input  logic [7:0]  joystick1,
    input  logic [7:0]  joystick2,
    input  logic [1:0]  start_button,
    input  logic [1:0]  coin_input,
    input  logic        service,
    input  logic        tilt,
    input  logic        dip_test,
    input  logic [7:0]  dipsw_a,
    input  logic [7:0]  dipsw_b,
    input  logic [7:0]  dipsw_c,
    output logic [7:0]  snd0_latch,
    output logic [7:0]  snd1_latch,
    output logic        ppu_rstn,
    output logic        ppu_cs,
    output logic        irq_vblank
);

    cpu_bus_if i_cpu_bus ();
    mem_req_if i_mem_req ();
    io_req_if  i_io_req ();

    bus_request_port i_bus_request_port (
        .clk   (clk),
        .rst   (rst),
        .req   (req),
        .we    (we),
        .be    (be),
        .iack  (iack),
        .addr  (addr),
        .wdata (wdata),
        .ack   (ack),
        .rdata (rdata),
        .bus   (i_cpu_bus)
    );

    access_sequencer i_access_sequencer (
        .clk (clk),
        .rst (rst),
        .cpu (i_cpu_bus),
        .mem (i_mem_req),
        .io  (i_io_req)
    );

    io_control i_io_control (
        .clk          (clk),
        .rst          (rst),
        .io           (i_io_req),
        .lvbl         (lvbl),
        .joystick1    (joystick1),
        .joystick2    (joystick2),
        .start_button (start_button),
        .coin_input   (coin_input),
        .service      (service),
        .tilt         (tilt),
        .dip_test     (dip_test),
        .dipsw_a      (dipsw_a),
        .dipsw_b      (dipsw_b),
        .dipsw_c      (dipsw_c),
        .snd0_latch   (snd0_latch),
        .snd1_latch   (snd1_latch),
        .ppu_rstn     (ppu_rstn),
        .ppu_cs       (ppu_cs),
        .irq_vblank   (irq_vblank)
    );

    memory_port i_memory_port (
        .clk       (clk),
        .rst       (rst),
        .mem       (i_mem_req),
        .rom_data  (rom_data),
        .rom_ok    (rom_ok),
        .ram_data  (ram_data),
        .ram_ok    (ram_ok),
        .rom_cs    (rom_cs),
        .rom_addr  (rom_addr),
        .ram_cs    (ram_cs),
        .vram_cs   (vram_cs),
        .ram_addr  (ram_addr),
        .ram_we    (ram_we),
        .ram_be    (ram_be),
        .ram_wdata (ram_wdata)
    );

endmodule

`default_nettype wire

/* sim/bus_checker.sv */
// Bus reference model and checker
`timescale 1ns/1ps
`default_nettype none

module bus_checker (
    input  logic        clk,
    input  logic        rst,
    input  logic        req,
    input  logic        we,
    input  logic [1:0]  be,
    input  logic        iack,
    input  logic [23:1] addr,
    input  logic [15:0] wdata,
    input  logic        ack,
    input  logic [15:0] rdata,
    input  logic        lvbl,
    input  logic [7:0]  joystick1,
    input  logic [7:0]  joystick2,
    input  logic [1:0]  start_button,
    input  logic [1:0]  coin_input,
    input  logic        service,
    input  logic        tilt,
    input  logic        dip_test,
    input  logic [7:0]  dipsw_a,
    input  logic [7:0]  dipsw_b,
    input  logic [7:0]  dipsw_c,
    input  logic [7:0]  snd0_latch,
    input  logic [7:0]  snd1_latch,
    input  logic        ppu_rstn,
    input  logic        ppu_cs,
    input  logic        irq_vblank,
    output int          test_count,
    output int          error_count
);
    import cps_bus_pkg::*;

    // shadow keyed by {vram, word address bits 17:1}
    logic [15:0] shadow [logic [17:0]];
    logic        ack_q;
    logic        req_q;
    logic        lvbl_q;
    int          wait_cnt;
    int          ppu_pulses;
    logic        m_irq;
    logic        m_rstn;
    logic [7:0]  m_snd0;
    logic [7:0]  m_snd1;
    logic        test_ok;

    // 0 unmapped, 1 ROM, 2 RAM, 3 VRAM, 4 I/O, 5 iack
    function automatic int region_of(input logic [23:1] a);
        if (a[23:22] == 2'b00) begin
            return 1;
        end else if (a[23:18] == 6'h3f) begin
            return 2;
        end else if (a[23:18] == 6'b100100 && a[17:16] != 2'b11) begin
            return 3;
        end else if (a[23:20] == 4'b1000) begin
            return 4;
        end
        return 0;
    endfunction

    function automatic string kind_name(input int kind);
        case (kind)
            1:       return "rom";
            2:       return "ram";
            3:       return "vram";
            4:       return "io";
            5:       return "iack";
            default: return "unmapped";
        endcase
    endfunction

    function automatic logic [15:0] initial_ram_word(input logic [17:0] key);
        return key[15:0] ^ {key[17:16], 14'h2a5};
    endfunction

    function automatic logic [15:0] cabinet_word(input logic [5:0] sel, input logic [1:0] idx);
        if (sel == IO_JOY) begin
            return {joystick2, joystick1};
        end else if (sel == IO_SYS) begin
            case (idx)
                2'd0:    return {tilt, dip_test, start_button, 1'b1, service, coin_input, 8'hff};
                2'd1:    return {dipsw_a, 8'hff};
                2'd2:    return {dipsw_b, 8'hff};
                default: return {dipsw_c, 8'hff};
            endcase
        end
        return 16'hffff;
    endfunction

    task automatic compare(input string what, input logic [15:0] exp, input logic [15:0] act);
        if (act !== exp) begin
            $display("[ERROR] %s expected %h actual %h", what, exp, act);
            error_count++;
            test_ok = 1'b0;
        end
    endtask

    task automatic report_fault(input string msg);
        $display("handshake error: %s", msg);
        error_count++;
    endtask

    // one completed access, seen on the rising ack
    task automatic finish_access();
        int          kind;
        int          pulses_due;
        int          slow_min;
        string       name;
        logic [15:0] expect_rd;
        logic [15:0] word;
        logic [17:0] key;
        logic        check_rd;
        kind       = iack ? 5 : region_of(addr);
        name       = $sformatf("%s_%s_%0d", kind_name(kind), we ? "write" : "read", test_count);
        pulses_due = 0;
        slow_min   = int'(SLOW_WAIT) + 2;
        check_rd   = !we;
        test_ok    = 1'b1;
        key        = {kind == 3, addr[17:1]};
        case (kind)
            1: expect_rd = addr[16:1] ^ 16'h5a5a;
            2, 3: begin
                word = shadow.exists(key) ? shadow[key] : initial_ram_word(key);
                if (we) begin
                    if (be[0]) begin
                        word[7:0] = wdata[7:0];
                    end
                    if (be[1]) begin
                        word[15:8] = wdata[15:8];
                    end
                    shadow[key] = word;
                end
                expect_rd = word;
            end
            4: begin
                expect_rd = cabinet_word(addr[8:3], addr[2:1]);
                if (we) begin
                    if (addr[8:3] == IO_OLATCH && be[1]) begin
                        m_rstn = ~wdata[15];
                    end
                    if (addr[8:3] == IO_SND0 && be[0]) begin
                        m_snd0 = wdata[7:0];
                    end
                    if (addr[8:3] == IO_SND1 && be[0]) begin
                        m_snd1 = wdata[7:0];
                    end
                    if (addr[8:6] == 3'b100) begin
                        pulses_due = 1;
                    end
                end
            end
            5: begin
                check_rd  = 1'b0;
                m_irq     = 1'b0;
                expect_rd = 16'hffff;
            end
            default: expect_rd = 16'hffff;
        endcase

        if (check_rd) begin
            compare({name, "_rdata"}, expect_rd, rdata);
        end
        compare({name, "_snd0"}, {8'h00, m_snd0}, {8'h00, snd0_latch});
        compare({name, "_snd1"}, {8'h00, m_snd1}, {8'h00, snd1_latch});
        compare({name, "_ppu_rstn"}, {15'd0, m_rstn}, {15'd0, ppu_rstn});
        compare({name, "_irq"}, {15'd0, m_irq}, {15'd0, irq_vblank});
        compare({name, "_ppu_cs_pulses"}, pulses_due[15:0], ppu_pulses[15:0]);
        // I/O, iack and unmapped run a fixed wait
        if (kind == 0 || kind == 4 || kind == 5) begin
            compare({name, "_latency"}, {13'd0, FAST_WAIT} + 16'd2, wait_cnt[15:0]);
        end else if (wait_cnt < slow_min) begin
            $display("%s: ack came after %0d cycles, before the minimum of %0d",
                     name, wait_cnt, slow_min);
            error_count++;
            test_ok = 1'b0;
        end
        test_count++;
        $display("%s %s", name, test_ok ? "passed" : "failed");
    endtask

    always @(posedge clk) begin
        if (rst) begin
            ack_q      = 1'b0;
            req_q      = 1'b0;
            lvbl_q     = 1'b0;
            wait_cnt   = 0;
            ppu_pulses = 0;
            m_irq      = 1'b0;
            m_rstn     = 1'b0;
            m_snd0     = 8'd0;
            m_snd1     = 8'd0;
        end else begin
            if (lvbl_q && !lvbl) begin
                m_irq = 1'b1;
            end
            if (ppu_cs) begin
                ppu_pulses++;
            end
            if (ack && !ack_q) begin
                if (!req_q) begin
                    report_fault("ack rose while req was low");
                end
                finish_access();
                wait_cnt   = 0;
                ppu_pulses = 0;
            end else if (!ack && ack_q && req_q) begin
                report_fault("ack fell while req was still high");
            end else if (req && !ack) begin
                wait_cnt++;
            end
            ack_q  = ack;
            req_q  = req;
            lvbl_q = lvbl;
        end
    end

endmodule

`default_nettype wire

/* sim/tb_cps_main_bus.sv */
// CPS main bus testbench
`timescale 1ns/1ps
`default_nettype none

module tb_cps_main_bus;
    import cps_bus_pkg::*;

    localparam int NUM_ACCESSES = 300;
    localparam int ACK_TIMEOUT  = 64;

    logic        clk = 1'b0;
    logic        rst;
    logic        req;
    logic        we;
    logic [1:0]  be;
    logic        iack;
    logic [23:1] addr;
    logic [15:0] wdata;
    logic        ack;
    logic [15:0] rdata;
    logic        rom_cs;
    logic [19:1] rom_addr;
    logic [15:0] rom_data = 16'd0;
    logic        rom_ok   = 1'b0;
    logic        ram_cs;
    logic        vram_cs;
    logic [17:1] ram_addr;
    logic        ram_we;
    logic [1:0]  ram_be;
    logic [15:0] ram_wdata;
    logic [15:0] ram_data = 16'd0;
    logic        ram_ok   = 1'b0;
    logic        lvbl;
    logic [7:0]  joystick1;
    logic [7:0]  joystick2;
    logic [1:0]  start_button;
    logic [1:0]  coin_input;
    logic        service;
    logic        tilt;
    logic        dip_test;
    logic [7:0]  dipsw_a;
    logic [7:0]  dipsw_b;
    logic [7:0]  dipsw_c;
    logic [7:0]  snd0_latch;
    logic [7:0]  snd1_latch;
    logic        ppu_rstn;
    logic        ppu_cs;
    logic        irq_vblank;
    int          test_count;
    int          error_count;
    logic        timed_out = 1'b0;

    // responder state
    logic [15:0] ram_mem [logic [17:0]];
    logic        rom_pending = 1'b0;
    logic        ram_pending = 1'b0;
    int          rom_delay;
    int          ram_delay;

    cps_main_bus i_cps_main_bus (.*);

    bus_checker i_bus_checker (.*);

    always #50 clk = ~clk;

    // unwritten RAM words, key is {vram, word address}
    function automatic logic [15:0] power_on_word(input logic [17:0] key);
        return key[15:0] ^ {key[17:16], 14'h2a5};
    endfunction

    function automatic logic [5:0] io_select(input logic [3:0] pick, input logic [5:0] raw);
        case (pick)
            4'd0:       return IO_JOY;
            4'd1, 4'd2: return IO_SYS;
            4'd3:       return IO_OLATCH;
            4'd4:       return IO_SND0;
            4'd5:       return IO_SND1;
            4'd6, 4'd7: return {3'b100, raw[2:0]};
            default:    return raw;
        endcase
    endfunction

    // ROM answers with the address pattern after a random delay
    always @(posedge clk) begin
        #5;
        rom_ok = 1'b0;
        if (rom_cs && !rom_pending) begin
            rom_pending = 1'b1;
            rom_delay   = $urandom_range(6, 0);
        end
        if (rom_pending) begin
            if (rom_delay == 0) begin
                rom_data    = rom_addr[16:1] ^ 16'h5a5a;
                rom_ok      = 1'b1;
                rom_pending = 1'b0;
            end else begin
                rom_delay--;
            end
        end
    end

    // work RAM and VRAM share one responder
    always @(posedge clk) begin
        logic [17:0] key;
        logic [15:0] word;
        #5;
        ram_ok = 1'b0;
        if ((ram_cs || vram_cs) && !ram_pending) begin
            ram_pending = 1'b1;
            ram_delay   = $urandom_range(6, 0);
        end
        if (ram_pending) begin
            if (ram_delay == 0) begin
                key  = {vram_cs, ram_addr};
                word = ram_mem.exists(key) ? ram_mem[key] : power_on_word(key);
                if (ram_we) begin
                    if (ram_be[0]) begin
                        word[7:0] = ram_wdata[7:0];
                    end
                    if (ram_be[1]) begin
                        word[15:8] = ram_wdata[15:8];
                    end
                    ram_mem[key] = word;
                end
                ram_data    = word;
                ram_ok      = 1'b1;
                ram_pending = 1'b0;
            end else begin
                ram_delay--;
            end
        end
    end

    task automatic shuffle_cabinet();
        logic [31:0] r;
        r            = $urandom;
        joystick1    = r[7:0];
        joystick2    = r[15:8];
        start_button = r[17:16];
        coin_input   = r[19:18];
        service      = r[20];
        tilt         = r[21];
        dip_test     = r[22];
        r            = $urandom;
        dipsw_a      = r[7:0];
        dipsw_b      = r[15:8];
        dipsw_c      = r[23:16];
        if (r[24]) begin
            lvbl = ~lvbl;
        end
    endtask

    // weighted pick over ROM, RAM, VRAM, I/O, unmapped and iack
    task automatic pick_request();
        logic [31:0] r;
        int          kind;
        r     = $urandom;
        kind  = $urandom_range(99, 0);
        we    = r[31];
        be    = r[30:29];
        wdata = r[15:0];
        iack  = 1'b0;
        r     = $urandom;
        if (kind < 15) begin
            addr = {2'b00, r[20:0]};
        end else if (kind < 30) begin
            addr = {6'h3f, r[5:4], 11'd0, r[3:0]};
        end else if (kind < 45) begin
            addr = {6'b100100, r[5:4], 11'd0, r[3:0]};
        end else if (kind < 75) begin
            addr = {4'b1000, r[20:10], io_select(r[9:6], r[27:22]), r[1:0]};
        end else if (kind < 90) begin
            case (r[22:21])
                2'd0:    addr = {2'b01, r[20:0]};
                2'd1:    addr = {3'b110, r[19:0]};
                2'd2:    addr = {4'b1011, r[18:0]};
                default: addr = {6'b100100, 2'b11, 11'd0, r[3:0]};
            endcase
        end else begin
            iack = 1'b1;
            addr = r[22:0];
        end
    endtask

    task automatic wait_ack(input logic level, input string what);
        int i;
        for (i = 0; i < ACK_TIMEOUT; i++) begin
            @(posedge clk);
            #5;
            if (ack == level) begin
                break;
            end
        end
        if (ack != level) begin
            $display("timeout: ack did not %s within %0d cycles", what, ACK_TIMEOUT);
            timed_out = 1'b1;
        end
    endtask

    initial begin
        int n;
        void'($urandom(32'h7478));
        rst   = 1'b1;
        req   = 1'b0;
        we    = 1'b0;
        be    = 2'b00;
        iack  = 1'b0;
        addr  = '0;
        wdata = 16'd0;
        lvbl  = 1'b1;
        shuffle_cabinet();
        repeat (2) @(posedge clk);
        #5;
        rst = 1'b0;

        for (n = 0; n < NUM_ACCESSES && !timed_out; n++) begin
            @(posedge clk);
            #5;
            shuffle_cabinet();
            // idle gap lets the vblank edge settle before the access
            repeat ($urandom_range(3, 1)) @(posedge clk);
            #5;
            pick_request();
            req = 1'b1;
            wait_ack(1'b1, "rise");
            if (!timed_out) begin
                // hold req past ack for some back-pressure
                repeat ($urandom_range(2, 1)) @(posedge clk);
                #5;
                req = 1'b0;
                wait_ack(1'b0, "fall");
            end
        end

        repeat (4) @(posedge clk);
        $display("%0d tests run, %0d errors", test_count, error_count);
        if (!timed_out && error_count == 0 && test_count == NUM_ACCESSES) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
verilog/cps_bus_pkg.sv
verilog/cps_bus_ifs.sv
verilog/bus_request_port.sv
verilog/access_sequencer.sv
verilog/io_control.sv
verilog/memory_port.sv
verilog/cps_main_bus.sv
sim/bus_checker.sv
sim/tb_cps_main_bus.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps
TOP       = tb_cps_main_bus
FILELIST  = project.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "TEST FAIL" $(LOG); then exit 1; fi; exit $$status

clean:
	rm -rf obj_dir $(LOG)
